// ==== Bender.yml ====
package:
  name: comp_unit

sources:
  - design/comp_pkg.sv
  - design/dma_tx_sink.sv
  - design/payload_fifo.sv
  - design/dma_rx_source.sv
  - design/dcr_status_regs.sv
  - design/comp_unit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/comp_unit_tb.sv

// ==== bench/comp_unit_tests.svh ====
`ifndef COMP_UNIT_TESTS_SVH
`define COMP_UNIT_TESTS_SVH

task automatic dcr_id_reads();
   dcr_read(comp_pkg::DCR_SIGNATURE, 32'haa55_55aa, "signature");
   dcr_read(comp_pkg::DCR_VERSION, 32'h1006_2500, "version");
endtask

// ten full words give a length header of 40
task automatic full_word_frame();
   run_frame(3'b101, 10, 4'b0000, 0, 1'b0);
   // count word follows ten payload words and the status word
   check("byte count of full frame", rx_d_q[11], 32'd40);
endtask

// odd word counts end on the upper half of an entry and even ones on the lower
task automatic partial_last_word();
   run_frame(3'b011, 7, 4'b0001, 0, 1'b0);
   run_frame(3'b110, 6, 4'b0011, 0, 1'b0);
   run_frame(3'b001, 9, 4'b0111, 0, 1'b0);
   run_frame(3'b100, 4, 4'b0001, 0, 1'b0);
endtask

task automatic length_mismatch();
   run_frame(3'b010, 5, 4'b0011, 3, 1'b0);
   dcr_read(comp_pkg::DCR_BYTE_CNT, {16'h0, last_cnt}, "byte count reg");
   dcr_read(comp_pkg::DCR_SRC_LEN, last_len, "source length reg");
   dcr_read(comp_pkg::DCR_FIELDS, {last_flags, 19'h0, last_task}, "fields reg");
endtask

// heavy stalls on the receive side back up the buffer
task automatic backpressure_stress();
   rx_stall = 70;
   tx_stalls = 0;
   run_frame(3'b111, 64, 4'b0111, 0, 1'b1);
   check("transmit stalled on a full buffer", tx_stalls != 0, 1);
   run_frame(3'b010, 33, 4'b0011, 0, 1'b1);
   rx_stall = 0;
   repeat (2) @(posedge clk);
   #1;
endtask

task automatic engine_reset_recovery();
   // leave a frame half done with its first beat stuck on the output
   rx_stall = 100;
   repeat (2) @(posedge clk);
   #1;
   pay_q.delete();
   repeat (4) pay_q.push_back($urandom);
   send_frame(3'b000, 32'd16, 10'd0, 4'b0000, 1'b0, 1'b0);
   repeat (4) @(posedge clk);
   #1;
   check("rx busy before reset", rx_src_rdy_n_o, 0);
   check("req before write", ll_rst_req_o, 0);
   // bit 31 of the big-endian bus is the rightmost bit
   dcr_addr_i = comp_pkg::DCR_RST_ADDR;
   dcr_wdata_i = 32'h0000_0001;
   dcr_write_i = 1'b1;
   @(posedge clk);
   #1;
   dcr_write_i = 1'b0;
   dcr_wdata_i = '0;
   check("req after write", ll_rst_req_o, 1);
   check("write ack", dcr_ack_o, 1);
   ll_rst_ack_i = 1'b1;
   @(posedge clk);
   #1;
   check("req one cycle only", ll_rst_req_o, 0);
   repeat (3) @(posedge clk);
   #1;
   ll_rst_ack_i = 1'b0;
   check_idle("after engine reset");
   @(posedge clk);
   #1;
   check("req stays low", ll_rst_req_o, 0);
   rx_stall = 0;
   repeat (2) @(posedge clk);
   #1;
   run_frame(3'b001, 8, 4'b0000, 0, 1'b0);
endtask

`endif

// ==== bench/comp_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module comp_unit_tb;

   // all tests together run well under a thousand cycles
   localparam int MAX_CYCLES = 20000;
   localparam int HDR = comp_pkg::HDR_WORDS;

   logic clk;
   logic rst_n;
   logic [31:0] tx_d_i;
   logic [3:0] tx_rem_i;
   logic tx_sof_n_i;
   logic tx_eof_n_i;
   logic tx_sop_n_i;
   logic tx_eop_n_i;
   logic tx_src_rdy_n_i;
   logic tx_dst_rdy_n_o;
   logic [31:0] rx_d_o;
   logic [3:0] rx_rem_o;
   logic rx_sof_n_o;
   logic rx_eof_n_o;
   logic rx_sop_n_o;
   logic rx_eop_n_o;
   logic rx_src_rdy_n_o;
   logic rx_dst_rdy_n_i;
   logic [0:comp_pkg::DCR_ADDR_W-1] dcr_addr_i;
   logic [0:comp_pkg::DCR_DATA_W-1] dcr_wdata_i;
   logic dcr_read_i;
   logic dcr_write_i;
   logic dcr_ack_o;
   logic [0:comp_pkg::DCR_DATA_W-1] dcr_rdata_o;
   logic ll_rst_req_o;
   logic ll_rst_ack_i;

   logic [31:0] rx_d_q[$];
   // {sof_n, sop_n, eop_n, eof_n, rem}
   logic [7:0] rx_ctl_q[$];
   logic [31:0] pay_q[$];
   int rx_stall;
   int tx_stalls;
   int errors;
   int checks;
   int cycles;
   logic [2:0] last_flags;
   logic [9:0] last_task;
   logic [31:0] last_len;
   logic [15:0] last_cnt;

   comp_unit #(.FIFO_DEPTH(8)) comp_unit_inst (
      .clk(clk), .rst_n(rst_n),
      .tx_d_i(tx_d_i), .tx_rem_i(tx_rem_i), .tx_sof_n_i(tx_sof_n_i),
      .tx_eof_n_i(tx_eof_n_i), .tx_sop_n_i(tx_sop_n_i), .tx_eop_n_i(tx_eop_n_i),
      .tx_src_rdy_n_i(tx_src_rdy_n_i), .tx_dst_rdy_n_o(tx_dst_rdy_n_o),
      .rx_d_o(rx_d_o), .rx_rem_o(rx_rem_o), .rx_sof_n_o(rx_sof_n_o),
      .rx_eof_n_o(rx_eof_n_o), .rx_sop_n_o(rx_sop_n_o), .rx_eop_n_o(rx_eop_n_o),
      .rx_src_rdy_n_o(rx_src_rdy_n_o), .rx_dst_rdy_n_i(rx_dst_rdy_n_i),
      .dcr_addr_i(dcr_addr_i), .dcr_wdata_i(dcr_wdata_i),
      .dcr_read_i(dcr_read_i), .dcr_write_i(dcr_write_i),
      .dcr_ack_o(dcr_ack_o), .dcr_rdata_o(dcr_rdata_o),
      .ll_rst_req_o(ll_rst_req_o), .ll_rst_ack_i(ll_rst_ack_i)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // rx_stall is the percentage of stalled receive cycles
   always @(posedge clk) begin
      #1;
      rx_dst_rdy_n_i = int'($urandom % 100) < rx_stall;
   end

   // receive monitor
   always @(posedge clk) begin
      if (rst_n && !rx_src_rdy_n_o && !rx_dst_rdy_n_i) begin
         rx_d_q.push_back(rx_d_o);
         rx_ctl_q.push_back({rx_sof_n_o, rx_sop_n_o, rx_eop_n_o, rx_eof_n_o, rx_rem_o});
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // valid bytes of the last transmit word sit at the high end
   function automatic int valid_bytes(input logic [3:0] rem);
      case (rem)
         4'b0001: return 3;
         4'b0011: return 2;
         4'b0111: return 1;
         default: return 4;
      endcase
   endfunction

   function automatic logic [31:0] keep_mask(input int n);
      case (n)
         3: return 32'hffff_ff00;
         2: return 32'hffff_0000;
         1: return 32'hff00_0000;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   function automatic logic [31:0] header_word(input int idx, input logic [2:0] flags,
                                               input logic [31:0] len, input logic [9:0] tidx);
      case (idx)
         comp_pkg::HDR_FLAG_IDX: return {flags, 29'h0};
         comp_pkg::HDR_LEN_IDX: return len;
         comp_pkg::HDR_TASK_IDX: return {22'h0, tidx};
         default: return 32'h5a5a_0000 | idx;
      endcase
   endfunction

   task automatic idle_tx();
      tx_src_rdy_n_i = 1'b1;
      tx_sof_n_i = 1'b1;
      tx_eof_n_i = 1'b1;
      tx_sop_n_i = 1'b1;
      tx_eop_n_i = 1'b1;
      tx_rem_i = 4'b0000;
   endtask

   // header then pay_q with EOF on the last word when with_eof is set
   task automatic send_frame(input logic [2:0] flags, input logic [31:0] len,
                             input logic [9:0] tidx, input logic [3:0] rem,
                             input bit gaps, input bit with_eof);
      int total;
      logic last;
      total = HDR + pay_q.size();
      for (int i = 0; i < total; i++) begin
         last = with_eof && (i == total - 1);
         while (gaps && ($urandom % 4 == 0)) begin
            tx_src_rdy_n_i = 1'b1;
            @(posedge clk);
            #1;
         end
         tx_d_i = (i < HDR) ? header_word(i, flags, len, tidx) : pay_q[i - HDR];
         tx_sof_n_i = (i != 0);
         tx_sop_n_i = (i != 0);
         tx_eof_n_i = !last;
         tx_eop_n_i = !last;
         tx_rem_i = last ? rem : 4'b0000;
         tx_src_rdy_n_i = 1'b0;
         do begin
            @(posedge clk);
            if (tx_dst_rdy_n_o)
               tx_stalls++;
         end while (tx_dst_rdy_n_o);
         #1;
      end
      idle_tx();
   endtask

   task automatic wait_rx_eof();
      while (rx_ctl_q.size() == 0 || rx_ctl_q[$][4]) begin
         @(posedge clk);
         #1;
      end
   endtask

   // sends one frame and compares the whole response with the expected one
   task automatic run_frame(input logic [2:0] flags, input int nwords,
                            input logic [3:0] rem, input int len_adj, input bit gaps);
      logic [31:0] exp_d[$];
      logic [7:0] exp_ctl[$];
      logic [31:0] w;
      int nbytes;
      bit last;
      pay_q.delete();
      rx_d_q.delete();
      rx_ctl_q.delete();
      for (int i = 0; i < nwords; i++)
         pay_q.push_back($urandom);
      nbytes = 4 * nwords - 4 + valid_bytes(rem);
      last_flags = flags;
      last_cnt = nbytes;
      last_len = nbytes + len_adj;
      last_task = $urandom;
      send_frame(flags, last_len, last_task, rem, gaps, 1'b1);
      wait_rx_eof();
      for (int i = 0; i < nwords; i++) begin
         last = (i == nwords - 1);
         w = last ? (pay_q[i] & keep_mask(valid_bytes(rem))) : pay_q[i];
         exp_d.push_back(w);
         exp_ctl.push_back({i != 0, i != 0, !last, 1'b1, last ? rem : 4'b0000});
      end
      exp_d.push_back({flags, len_adj == 0, 28'h0});
      exp_ctl.push_back(8'hf0);
      exp_d.push_back({16'h0, last_cnt});
      exp_ctl.push_back(8'hf0);
      exp_d.push_back({22'h0, last_task});
      exp_ctl.push_back(8'he0);
      check("rx beat count", rx_d_q.size(), exp_d.size());
      for (int i = 0; i < exp_d.size() && i < rx_d_q.size(); i++) begin
         check($sformatf("rx data beat %0d", i), rx_d_q[i], exp_d[i]);
         check($sformatf("rx controls beat %0d", i), rx_ctl_q[i], exp_ctl[i]);
      end
   endtask

   task automatic dcr_read(input logic [3:0] reg_num, input logic [31:0] exp,
                           input string what);
      dcr_addr_i = reg_num;
      dcr_read_i = 1'b1;
      @(posedge clk);
      #1;
      dcr_read_i = 1'b0;
      check({what, " ack"}, dcr_ack_o, 1);
      check(what, dcr_rdata_o, exp);
      @(posedge clk);
      #1;
      check({what, " ack drop"}, dcr_ack_o, 0);
   endtask

   task automatic check_idle(input string what);
      check({what, " tx_dst_rdy_n"}, tx_dst_rdy_n_o, 0);
      check({what, " rx controls"},
            {rx_src_rdy_n_o, rx_sof_n_o, rx_sop_n_o, rx_eop_n_o, rx_eof_n_o}, 5'b11111);
      check({what, " ll_rst_req"}, ll_rst_req_o, 0);
      check({what, " dcr_ack"}, dcr_ack_o, 0);
   endtask

`include "comp_unit_tests.svh"

   initial begin
      void'($urandom(32'hfb86fd57));
      errors = 0;
      checks = 0;
      cycles = 0;
      rx_stall = 0;
      tx_stalls = 0;
      rst_n = 1'b0;
      tx_d_i = '0;
      idle_tx();
      rx_dst_rdy_n_i = 1'b0;
      dcr_addr_i = '0;
      dcr_wdata_i = '0;
      dcr_read_i = 1'b0;
      dcr_write_i = 1'b0;
      ll_rst_ack_i = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      check_idle("after reset");
      dcr_id_reads();
      full_word_frame();
      partial_last_word();
      length_mismatch();
      backpressure_stress();
      engine_reset_recovery();
      repeat (4) @(posedge clk);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== comp_unit.f ====
+incdir+bench
design/comp_pkg.sv
design/dma_tx_sink.sv
design/payload_fifo.sv
design/dma_rx_source.sv
design/dcr_status_regs.sv
design/comp_unit.sv
bench/comp_unit_tb.sv

// ==== design/comp_pkg.sv ====
`default_nettype none

package comp_pkg;

   localparam int LL_DATA_W = 32;
   localparam int LL_REM_W = 4;
   localparam int ENTRY_W = 2 * LL_DATA_W;

   // header layout of a transmit frame
   localparam int HDR_WORDS = 8;
   localparam int HDR_FLAG_IDX = 4;
   localparam int HDR_LEN_IDX = 5;
   localparam int HDR_TASK_IDX = 6;

   localparam int TASK_W = 10;
   localparam int CNT_W = 16;

   localparam int DCR_ADDR_W = 10;
   localparam int DCR_DATA_W = 32;

   // register numbers in the low four address bits
   localparam logic [3:0] DCR_TX_STAT = 4'd0;
   localparam logic [3:0] DCR_RX_STAT = 4'd1;
   localparam logic [3:0] DCR_FIELDS = 4'd2;
   localparam logic [3:0] DCR_BYTE_CNT = 4'd3;
   localparam logic [3:0] DCR_SRC_LEN = 4'd4;
   localparam logic [3:0] DCR_VERSION = 4'd14;
   localparam logic [3:0] DCR_SIGNATURE = 4'd15;

   localparam logic [DCR_ADDR_W-1:0] DCR_RST_ADDR = '0;
   localparam logic [DCR_DATA_W-1:0] VERSION_WORD = 32'h1006_2500;
   localparam logic [DCR_DATA_W-1:0] SIGNATURE_WORD = 32'haa55_55aa;

   typedef enum logic [3:0] {
      TX_IDLE,
      TX_HEAD,
      TX_WORD0,
      TX_WORD1,
      TX_WAIT
   } tx_state_e;

   // named after the word that is loaded next
   typedef enum logic [3:0] {
      RX_IDLE,
      RX_UPPER,
      RX_LOWER,
      RX_WAIT,
      RX_CNT,
      RX_TASK,
      RX_DONE
   } rx_state_e;

   // flag header word and trailer status word share this layout
   typedef union packed {
      logic [LL_DATA_W-1:0] raw;
      struct packed {
         logic [2:0] op;
         logic status;
         logic [LL_DATA_W-5:0] rsvd;
      } desc;
   } ll_word_u;

endpackage

`default_nettype wire

// ==== design/comp_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module comp_unit #(
   parameter int FIFO_DEPTH = 8
) (
   input  wire clk,
   input  wire rst_n,
   input  wire [comp_pkg::LL_DATA_W-1:0] tx_d_i,
   input  wire [comp_pkg::LL_REM_W-1:0] tx_rem_i,
   input  wire tx_sof_n_i,
   input  wire tx_eof_n_i,
   input  wire tx_sop_n_i,
   input  wire tx_eop_n_i,
   input  wire tx_src_rdy_n_i,
   output logic tx_dst_rdy_n_o,
   output logic [comp_pkg::LL_DATA_W-1:0] rx_d_o,
   output logic [comp_pkg::LL_REM_W-1:0] rx_rem_o,
   output logic rx_sof_n_o,
   output logic rx_eof_n_o,
   output logic rx_sop_n_o,
   output logic rx_eop_n_o,
   output logic rx_src_rdy_n_o,
   input  wire rx_dst_rdy_n_i,
   input  wire [0:comp_pkg::DCR_ADDR_W-1] dcr_addr_i,
   input  wire [0:comp_pkg::DCR_DATA_W-1] dcr_wdata_i,
   input  wire dcr_read_i,
   input  wire dcr_write_i,
   output logic dcr_ack_o,
   output logic [0:comp_pkg::DCR_DATA_W-1] dcr_rdata_o,
   output logic ll_rst_req_o,
   input  wire ll_rst_ack_i
);

   logic dp_rst_n;
   logic wr_en;
   logic [comp_pkg::ENTRY_W-1:0] wr_data;
   logic wr_last;
   logic rd_en;
   logic [comp_pkg::ENTRY_W-1:0] rd_data;
   logic rd_last;
   logic fifo_full;
   logic fifo_empty;
   logic frame_ready;
   logic frame_done;
   logic [2:0] flags;
   logic [comp_pkg::TASK_W-1:0] task_idx;
   logic [comp_pkg::LL_DATA_W-1:0] src_len;
   logic [comp_pkg::CNT_W-1:0] byte_cnt;
   logic [comp_pkg::LL_REM_W-1:0] last_rem;
   logic len_ok;
   comp_pkg::tx_state_e tx_state;
   comp_pkg::rx_state_e rx_state;

   // datapath also held in reset across the engine reset handshake
   assign dp_rst_n = rst_n && !ll_rst_req_o && !ll_rst_ack_i;

   dma_tx_sink dma_tx_sink_inst (
      .clk(clk), .rst_n(dp_rst_n),
      .tx_d_i(tx_d_i), .tx_rem_i(tx_rem_i), .tx_sof_n_i(tx_sof_n_i),
      .tx_eof_n_i(tx_eof_n_i), .tx_src_rdy_n_i(tx_src_rdy_n_i),
      .fifo_full_i(fifo_full), .frame_done_i(frame_done),
      .tx_dst_rdy_n_o(tx_dst_rdy_n_o), .fifo_wr_en_o(wr_en),
      .fifo_wr_data_o(wr_data), .fifo_wr_last_o(wr_last),
      .frame_ready_o(frame_ready), .flags_o(flags), .task_idx_o(task_idx),
      .src_len_o(src_len), .byte_cnt_o(byte_cnt), .last_rem_o(last_rem),
      .len_ok_o(len_ok), .state_o(tx_state)
   );

   payload_fifo #(.DEPTH(FIFO_DEPTH)) payload_fifo_inst (
      .clk(clk), .rst_n(dp_rst_n),
      .wr_en_i(wr_en), .wr_data_i(wr_data), .wr_last_i(wr_last), .rd_en_i(rd_en),
      .rd_data_o(rd_data), .rd_last_o(rd_last), .full_o(fifo_full), .empty_o(fifo_empty)
   );

   dma_rx_source dma_rx_source_inst (
      .clk(clk), .rst_n(dp_rst_n),
      .fifo_rd_data_i(rd_data), .fifo_rd_last_i(rd_last), .fifo_empty_i(fifo_empty),
      .frame_ready_i(frame_ready), .flags_i(flags), .task_idx_i(task_idx),
      .byte_cnt_i(byte_cnt), .last_rem_i(last_rem), .len_ok_i(len_ok),
      .rx_dst_rdy_n_i(rx_dst_rdy_n_i), .fifo_rd_en_o(rd_en),
      .rx_d_o(rx_d_o), .rx_rem_o(rx_rem_o), .rx_sof_n_o(rx_sof_n_o),
      .rx_eof_n_o(rx_eof_n_o), .rx_sop_n_o(rx_sop_n_o), .rx_eop_n_o(rx_eop_n_o),
      .rx_src_rdy_n_o(rx_src_rdy_n_o), .frame_done_o(frame_done), .state_o(rx_state)
   );

   dcr_status_regs dcr_status_regs_inst (
      .clk(clk), .rst_n(rst_n),
      .dcr_addr_i(dcr_addr_i), .dcr_wdata_i(dcr_wdata_i),
      .dcr_read_i(dcr_read_i), .dcr_write_i(dcr_write_i),
      .tx_state_i(tx_state), .rx_state_i(rx_state),
      .tx_rdy_bits_i({tx_src_rdy_n_i, tx_dst_rdy_n_o, tx_sop_n_i, tx_eop_n_i}),
      .rx_rdy_bits_i({rx_src_rdy_n_o, rx_dst_rdy_n_i, rx_sop_n_o, rx_eop_n_o}),
      .flags_i(flags), .task_idx_i(task_idx), .byte_cnt_i(byte_cnt), .src_len_i(src_len),
      .dcr_ack_o(dcr_ack_o), .dcr_rdata_o(dcr_rdata_o), .ll_rst_req_o(ll_rst_req_o)
   );

endmodule

`default_nettype wire

// ==== design/dcr_status_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcr_status_regs (
   input  wire clk,
   input  wire rst_n,
   input  wire [0:comp_pkg::DCR_ADDR_W-1] dcr_addr_i,
   input  wire [0:comp_pkg::DCR_DATA_W-1] dcr_wdata_i,
   input  wire dcr_read_i,
   input  wire dcr_write_i,
   input  wire comp_pkg::tx_state_e tx_state_i,
   input  wire comp_pkg::rx_state_e rx_state_i,
   input  wire [3:0] tx_rdy_bits_i,
   input  wire [3:0] rx_rdy_bits_i,
   input  wire [2:0] flags_i,
   input  wire [comp_pkg::TASK_W-1:0] task_idx_i,
   input  wire [comp_pkg::CNT_W-1:0] byte_cnt_i,
   input  wire [comp_pkg::LL_DATA_W-1:0] src_len_i,
   output logic dcr_ack_o,
   output logic [0:comp_pkg::DCR_DATA_W-1] dcr_rdata_o,
   output logic ll_rst_req_o
);

   localparam int DW = comp_pkg::DCR_DATA_W;

   logic [0:DW-1] rd_mux;
   logic [3:0] reg_sel;

   assign reg_sel = dcr_addr_i[comp_pkg::DCR_ADDR_W-4:comp_pkg::DCR_ADDR_W-1];

   // big-endian bus, fields sit at the low-numbered end
   always_comb begin
      rd_mux = '0;
      case (reg_sel)
         comp_pkg::DCR_TX_STAT: begin
            rd_mux[0:3] = tx_state_i;
            rd_mux[4:7] = tx_rdy_bits_i;
         end
         comp_pkg::DCR_RX_STAT: begin
            rd_mux[0:3] = rx_state_i;
            rd_mux[4:7] = rx_rdy_bits_i;
         end
         comp_pkg::DCR_FIELDS: begin
            rd_mux[0:2] = flags_i;
            rd_mux[DW-comp_pkg::TASK_W:DW-1] = task_idx_i;
         end
         comp_pkg::DCR_BYTE_CNT: rd_mux[DW-comp_pkg::CNT_W:DW-1] = byte_cnt_i;
         comp_pkg::DCR_SRC_LEN: rd_mux = src_len_i;
         comp_pkg::DCR_VERSION: rd_mux = comp_pkg::VERSION_WORD;
         comp_pkg::DCR_SIGNATURE: rd_mux = comp_pkg::SIGNATURE_WORD;
         default: rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dcr_ack_o <= 1'b0;
         ll_rst_req_o <= 1'b0;
      end else begin
         dcr_ack_o <= dcr_read_i || dcr_write_i;
         // one-cycle engine reset pulse
         ll_rst_req_o <= dcr_write_i && (dcr_addr_i == comp_pkg::DCR_RST_ADDR) &&
                         dcr_wdata_i[DW-1];
      end
   end

   always_ff @(posedge clk) begin
      if (dcr_read_i)
         dcr_rdata_o <= rd_mux;
   end

endmodule

`default_nettype wire

// ==== design/dma_rx_source.sv ====
`timescale 1ns/1ns
`default_nettype none

module dma_rx_source (
   input  wire clk,
   input  wire rst_n,
   input  wire [comp_pkg::ENTRY_W-1:0] fifo_rd_data_i,
   input  wire fifo_rd_last_i,
   input  wire fifo_empty_i,
   input  wire frame_ready_i,
   input  wire [2:0] flags_i,
   input  wire [comp_pkg::TASK_W-1:0] task_idx_i,
   input  wire [comp_pkg::CNT_W-1:0] byte_cnt_i,
   input  wire [comp_pkg::LL_REM_W-1:0] last_rem_i,
   input  wire len_ok_i,
   input  wire rx_dst_rdy_n_i,
   output logic fifo_rd_en_o,
   output logic [comp_pkg::LL_DATA_W-1:0] rx_d_o,
   output logic [comp_pkg::LL_REM_W-1:0] rx_rem_o,
   output logic rx_sof_n_o,
   output logic rx_eof_n_o,
   output logic rx_sop_n_o,
   output logic rx_eop_n_o,
   output logic rx_src_rdy_n_o,
   output logic frame_done_o,
   output comp_pkg::rx_state_e state_o
);

   comp_pkg::rx_state_e state;
   comp_pkg::ll_word_u status;
   logic [2:0] bc_m1;
   logic upper_end;
   logic beat;
   logic can_load;

   assign beat = !rx_src_rdy_n_o && !rx_dst_rdy_n_i;
   // output slot is free when empty or when its beat moves now
   assign can_load = rx_src_rdy_n_o || beat;
   assign frame_done_o = beat && !rx_eof_n_o;
   assign state_o = state;

   // odd word count leaves 1 to 4 bytes in the last entry
   assign bc_m1 = byte_cnt_i[2:0] - 3'd1;
   assign upper_end = fifo_rd_last_i && !bc_m1[2];

   assign fifo_rd_en_o = can_load && !fifo_empty_i &&
                         ((state == comp_pkg::RX_LOWER) ||
                          ((state == comp_pkg::RX_IDLE || state == comp_pkg::RX_UPPER) &&
                           upper_end));

   always_comb begin
      status = '0;
      status.desc.op = flags_i;
      status.desc.status = len_ok_i;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= comp_pkg::RX_IDLE;
         rx_src_rdy_n_o <= 1'b1;
         rx_sof_n_o <= 1'b1;
         rx_sop_n_o <= 1'b1;
         rx_eop_n_o <= 1'b1;
         rx_eof_n_o <= 1'b1;
      end else if (can_load) begin
         rx_src_rdy_n_o <= 1'b1;
         rx_sof_n_o <= 1'b1;
         rx_sop_n_o <= 1'b1;
         rx_eop_n_o <= 1'b1;
         rx_eof_n_o <= 1'b1;
         case (state)
            comp_pkg::RX_IDLE, comp_pkg::RX_UPPER: begin
               if (!fifo_empty_i) begin
                  rx_src_rdy_n_o <= 1'b0;
                  rx_sof_n_o <= (state != comp_pkg::RX_IDLE);
                  rx_sop_n_o <= (state != comp_pkg::RX_IDLE);
                  rx_eop_n_o <= !upper_end;
                  state <= upper_end ? comp_pkg::RX_WAIT : comp_pkg::RX_LOWER;
               end
            end
            comp_pkg::RX_LOWER: begin
               rx_src_rdy_n_o <= 1'b0;
               rx_eop_n_o <= !fifo_rd_last_i;
               state <= fifo_rd_last_i ? comp_pkg::RX_WAIT : comp_pkg::RX_UPPER;
            end
            comp_pkg::RX_WAIT: begin
               if (frame_ready_i) begin
                  rx_src_rdy_n_o <= 1'b0;
                  state <= comp_pkg::RX_CNT;
               end
            end
            comp_pkg::RX_CNT: begin
               rx_src_rdy_n_o <= 1'b0;
               state <= comp_pkg::RX_TASK;
            end
            comp_pkg::RX_TASK: begin
               rx_src_rdy_n_o <= 1'b0;
               rx_eof_n_o <= 1'b0;
               state <= comp_pkg::RX_DONE;
            end
            // trailer EOF has moved
            default: state <= comp_pkg::RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (can_load) begin
         case (state)
            comp_pkg::RX_IDLE, comp_pkg::RX_UPPER: begin
               rx_d_o <= fifo_rd_data_i[comp_pkg::ENTRY_W-1 -: comp_pkg::LL_DATA_W];
               rx_rem_o <= upper_end ? last_rem_i : '0;
            end
            comp_pkg::RX_LOWER: begin
               rx_d_o <= fifo_rd_data_i[comp_pkg::LL_DATA_W-1:0];
               rx_rem_o <= fifo_rd_last_i ? last_rem_i : '0;
            end
            comp_pkg::RX_WAIT: begin
               rx_d_o <= status.raw;
               rx_rem_o <= '0;
            end
            comp_pkg::RX_CNT: begin
               rx_d_o <= {{(comp_pkg::LL_DATA_W-comp_pkg::CNT_W){1'b0}}, byte_cnt_i};
            end
            comp_pkg::RX_TASK: begin
               rx_d_o <= {{(comp_pkg::LL_DATA_W-comp_pkg::TASK_W){1'b0}}, task_idx_i};
            end
            default: rx_rem_o <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/dma_tx_sink.sv ====
`timescale 1ns/1ns
`default_nettype none

module dma_tx_sink (
   input  wire clk,
   input  wire rst_n,
   input  wire [comp_pkg::LL_DATA_W-1:0] tx_d_i,
   input  wire [comp_pkg::LL_REM_W-1:0] tx_rem_i,
   input  wire tx_sof_n_i,
   input  wire tx_eof_n_i,
   input  wire tx_src_rdy_n_i,
   input  wire fifo_full_i,
   input  wire frame_done_i,
   output logic tx_dst_rdy_n_o,
   output logic fifo_wr_en_o,
   output logic [comp_pkg::ENTRY_W-1:0] fifo_wr_data_o,
   output logic fifo_wr_last_o,
   output logic frame_ready_o,
   output logic [2:0] flags_o,
   output logic [comp_pkg::TASK_W-1:0] task_idx_o,
   output logic [comp_pkg::LL_DATA_W-1:0] src_len_o,
   output logic [comp_pkg::CNT_W-1:0] byte_cnt_o,
   output logic [comp_pkg::LL_REM_W-1:0] last_rem_o,
   output logic len_ok_o,
   output comp_pkg::tx_state_e state_o
);

   comp_pkg::tx_state_e state;
   comp_pkg::ll_word_u hdr;
   logic [$clog2(comp_pkg::HDR_WORDS)-1:0] hdr_cnt;
   logic [comp_pkg::LL_DATA_W-1:0] word0;
   logic [comp_pkg::LL_DATA_W-1:0] masked;
   logic [2:0] beat_bytes;
   logic [comp_pkg::CNT_W-1:0] cnt_next;
   logic beat;
   logic last;

   // stall on a full buffer and while the response is still going out
   assign tx_dst_rdy_n_o = fifo_full_i || (state == comp_pkg::TX_WAIT);
   assign beat = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;
   assign last = !tx_eof_n_i;
   assign hdr = tx_d_i;
   assign state_o = state;
   assign cnt_next = byte_cnt_o + {{(comp_pkg::CNT_W-3){1'b0}}, beat_bytes};

   // rem bits mark dropped bytes of the last word, low end first
   always_comb begin
      masked = tx_d_i;
      beat_bytes = 3'd4;
      if (last) begin
         for (int i = 0; i < comp_pkg::LL_REM_W; i++) begin
            if (tx_rem_i[i]) begin
               masked[8*i +: 8] = 8'h00;
               beat_bytes = beat_bytes - 3'd1;
            end
         end
      end
   end

   // a pair goes out when full, or early at EOF with a zero lower half
   assign fifo_wr_en_o = beat && ((state == comp_pkg::TX_WORD1) ||
                                  (state == comp_pkg::TX_WORD0 && last));
   assign fifo_wr_data_o = (state == comp_pkg::TX_WORD1) ? {word0, masked} :
                           {masked, {comp_pkg::LL_DATA_W{1'b0}}};
   assign fifo_wr_last_o = last;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= comp_pkg::TX_IDLE;
         hdr_cnt <= '0;
         byte_cnt_o <= '0;
         frame_ready_o <= 1'b0;
      end else begin
         case (state)
            comp_pkg::TX_IDLE: begin
               if (beat && !tx_sof_n_i) begin
                  state <= comp_pkg::TX_HEAD;
                  hdr_cnt <= 1'b1;
                  byte_cnt_o <= '0;
               end
            end
            comp_pkg::TX_HEAD: begin
               if (beat) begin
                  hdr_cnt <= hdr_cnt + 1'b1;
                  if (hdr_cnt == comp_pkg::HDR_WORDS - 1)
                     state <= comp_pkg::TX_WORD0;
               end
            end
            comp_pkg::TX_WORD0, comp_pkg::TX_WORD1: begin
               if (beat) begin
                  byte_cnt_o <= cnt_next;
                  if (last) begin
                     state <= comp_pkg::TX_WAIT;
                     frame_ready_o <= 1'b1;
                  end else if (state == comp_pkg::TX_WORD0) begin
                     state <= comp_pkg::TX_WORD1;
                  end else begin
                     state <= comp_pkg::TX_WORD0;
                  end
               end
            end
            comp_pkg::TX_WAIT: begin
               if (frame_done_i) begin
                  state <= comp_pkg::TX_IDLE;
                  frame_ready_o <= 1'b0;
               end
            end
            default: state <= comp_pkg::TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (beat && state == comp_pkg::TX_HEAD) begin
         if (hdr_cnt == comp_pkg::HDR_FLAG_IDX)
            flags_o <= hdr.desc.op;
         if (hdr_cnt == comp_pkg::HDR_LEN_IDX)
            src_len_o <= tx_d_i;
         if (hdr_cnt == comp_pkg::HDR_TASK_IDX)
            task_idx_o <= tx_d_i[comp_pkg::TASK_W-1:0];
      end
      if (beat && state == comp_pkg::TX_WORD0)
         word0 <= masked;
      if (fifo_wr_en_o && last) begin
         last_rem_o <= tx_rem_i;
         len_ok_o <= (cnt_next == src_len_o[comp_pkg::CNT_W-1:0]);
      end
   end

endmodule

`default_nettype wire

// ==== design/payload_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module payload_fifo #(
   parameter int DEPTH = 8
) (
   input  wire clk,
   input  wire rst_n,
   input  wire wr_en_i,
   input  wire [comp_pkg::ENTRY_W-1:0] wr_data_i,
   input  wire wr_last_i,
   input  wire rd_en_i,
   output logic [comp_pkg::ENTRY_W-1:0] rd_data_o,
   output logic rd_last_o,
   output logic full_o,
   output logic empty_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // each slot keeps the last-entry flag above the data
   logic [comp_pkg::ENTRY_W:0] mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic do_wr;
   logic do_rd;

   assign full_o = (count == DEPTH);
   assign empty_o = (count == 0);
   assign do_wr = wr_en_i && !full_o;
   assign do_rd = rd_en_i && !empty_o;
   assign {rd_last_o, rd_data_o} = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= {wr_last_i, wr_data_i};
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire
